/* src/accPkg.sv */
// Single-bank build; instruction fields sit in the low bits and the upper bits are ignored
`default_nettype none

package accPkg;

    // Bus and buffer geometry
    localparam int PortWidth = 128;
    localparam int SramWidth = 256;
    localparam int SramWord  = 128;
    localparam int AddrWidth = 7;
    localparam int NumWidth  = 8;

    typedef logic [SramWidth-1:0] sramWordT;

    // Code 2'b11 is illegal
    typedef enum logic [1:0] {
        OpLoad   = 2'd0,
        OpStore  = 2'd1,
        OpFinish = 2'd2
    } opcodeT;

    typedef struct packed {
        logic [SramWidth-2-NumWidth-AddrWidth-1:0] reserved;
        opcodeT                                    opcode;
        logic [NumWidth-1:0]                       wordNum;
        logic [AddrWidth-1:0]                      glbAddr;
    } instrT;

    // One host word, seen as payload or as an instruction
    typedef union packed {
        sramWordT raw;
        instrT    instr;
    } ccuWordT;

endpackage

`default_nettype wire

/* src/itfStreamIf.sv */
// Valid/ready in both directions; valid and data must hold until the word moves
`default_nettype none

interface itfStreamIf;
    import accPkg::*;

    logic     dirOut;
    sramWordT inWord;
    logic     inVld;
    logic     inRdy;
    sramWordT outWord;
    logic     outLast;
    logic     outVld;
    logic     outRdy;

    modport ccu (output dirOut, input inWord, input inVld, output inRdy,
                 output outWord, output outLast, output outVld, input outRdy);

    modport itf (input dirOut, output inWord, output inVld, input inRdy,
                 input outWord, input outLast, input outVld, output outRdy);

endinterface

`default_nettype wire

/* src/glbPortIf.sv */
// No back-pressure on either port; read data returns one cycle after rdEn
`default_nettype none

interface glbPortIf;
    import accPkg::*;

    logic                 wrEn;
    logic [AddrWidth-1:0] wrAddr;
    sramWordT             wrDat;
    logic                 rdEn;
    logic [AddrWidth-1:0] rdAddr;
    sramWordT             rdDat;
    logic                 rdVld;

    modport ccu (output wrEn, output wrAddr, output wrDat,
                 output rdEn, output rdAddr, input rdDat, input rdVld);

    modport glb (input wrEn, input wrAddr, input wrDat,
                 input rdEn, input rdAddr, output rdDat, output rdVld);

endinterface

`default_nettype wire

/* src/startDebounce.sv */
// Button is active high and asynchronous; DebCycles must be at least 1
`default_nettype none

module startDebounce #(
    parameter int DebCycles = 16
) (
    input  logic clk,
    input  logic rstN,
    input  logic btn,
    output logic startPls
);
    localparam int CntWidth = $clog2(DebCycles + 1);

    logic                btnMeta;
    logic                btnSmp;
    logic                level;
    logic                levelDly;
    logic [CntWidth-1:0] cnt;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            btnMeta  <= 1'b0;
            btnSmp   <= 1'b0;
            level    <= 1'b0;
            levelDly <= 1'b0;
            startPls <= 1'b0;
            cnt      <= '0;
        end else begin
            // Two-stage synchronizer
            btnMeta  <= btn;
            btnSmp   <= btnMeta;
            levelDly <= level;
            // Release of the button starts the run
            startPls <= levelDly && !level;
            if (btnSmp == level) begin
                cnt <= '0;
            end else if (cnt == CntWidth'(DebCycles - 1)) begin
                level <= btnSmp;
                cnt   <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/padItf.sv */
// Host must hold valid and data until ready; low half goes first and padDatLast is not sampled
`default_nettype none

module padItf (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic [accPkg::PortWidth-1:0] padDatIn,
    input  logic                         padVldIn,
    input  logic                         padRdyIn,
    output logic [accPkg::PortWidth-1:0] padDatOut,
    output logic                         padVldOut,
    output logic                         padLastOut,
    output logic                         padRdyOut,
    output logic                         datOe,
    itfStreamIf.itf                      strm
);
    import accPkg::*;

    logic [PortWidth-1:0] halfReg;
    logic                 beatSel;
    sramWordT             outWordReg;
    logic                 outLastReg;
    logic                 outFull;
    logic                 outBeat;
    logic                 inBeatGo;
    logic                 outBeatGo;
    logic                 outLoad;

    // ========================================================================
    // Host to chip
    // ========================================================================
    assign padRdyOut = !datOe && strm.inRdy;
    assign inBeatGo  = padVldIn && padRdyOut;

    // Word is offered together with its high beat
    assign strm.inWord = {padDatIn, halfReg};
    assign strm.inVld  = !datOe && padVldIn && beatSel;

    always_ff @(posedge clk) begin
        if (inBeatGo && !beatSel) begin
            halfReg <= padDatIn;
        end
    end

    // ========================================================================
    // Chip to host
    // ========================================================================
    assign padVldOut  = datOe && outFull;
    assign padDatOut  = outBeat ? outWordReg[SramWidth-1:PortWidth] : outWordReg[PortWidth-1:0];
    assign padLastOut = padVldOut && outBeat && outLastReg;
    assign outBeatGo  = padVldOut && padRdyIn;

    // Next word may load while the high beat of the current one leaves
    assign strm.outRdy = datOe && (!outFull || (outBeatGo && outBeat));
    assign outLoad     = strm.outVld && strm.outRdy;

    always_ff @(posedge clk) begin
        if (outLoad) begin
            outWordReg <= strm.outWord;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            beatSel    <= 1'b0;
            outFull    <= 1'b0;
            outBeat    <= 1'b0;
            outLastReg <= 1'b0;
            datOe      <= 1'b0;
        end else begin
            if (inBeatGo) begin
                beatSel <= !beatSel;
            end
            if (outLoad) begin
                outFull    <= 1'b1;
                outBeat    <= 1'b0;
                outLastReg <= strm.outLast;
            end else if (outBeatGo) begin
                if (outBeat) begin
                    outFull <= 1'b0;
                end
                outBeat <= !outBeat;
            end
            // Turn the bus around only between words
            if (!beatSel && !outFull) begin
                datOe <= strm.dirOut;
            end
        end
    end

    // Stalled beat stays on the pads
    assert property (@(posedge clk) disable iff (!rstN)
        (padVldOut && !padRdyIn) |=> (padVldOut && $stable(padDatOut)))
        else $error("padItf: output beat changed while stalled");

endmodule

`default_nettype wire

/* src/globalBuffer.sv */
// One write and one read port per cycle; a read of the address being written returns old data
`default_nettype none

module globalBuffer #(
    parameter int Depth = accPkg::SramWord
) (
    input  logic  clk,
    input  logic  rstN,
    glbPortIf.glb port
);
    import accPkg::*;

    sramWordT mem [Depth];

    always_ff @(posedge clk) begin
        if (port.wrEn) begin
            mem[port.wrAddr] <= port.wrDat;
        end
        if (port.rdEn) begin
            port.rdDat <= mem[port.rdAddr];
        end
    end

    // Valid marks the cycle the read data is present
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            port.rdVld <= 1'b0;
        end else begin
            port.rdVld <= port.rdEn;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        port.wrEn |-> (port.wrAddr < Depth))
        else $error("globalBuffer: write address out of range");

    assert property (@(posedge clk) disable iff (!rstN)
        port.rdEn |-> (port.rdAddr < Depth))
        else $error("globalBuffer: read address out of range");

endmodule

`default_nettype wire

/* src/ccuSequencer.sv */
// Runs LOAD, STORE and FINISH only; a zero word count makes LOAD or STORE a no-op
`default_nettype none

module ccuSequencer (
    input  logic    clk,
    input  logic    rstN,
    input  logic    start,
    output logic    netFnh,
    itfStreamIf.ccu strm,
    glbPortIf.ccu   glb
);
    import accPkg::*;

    localparam logic [1:0] StIdle  = 2'd0;
    localparam logic [1:0] StFetch = 2'd1;
    localparam logic [1:0] StLoad  = 2'd2;
    localparam logic [1:0] StStore = 2'd3;

    logic [1:0]           state;
    logic [AddrWidth-1:0] addr;
    logic [NumWidth-1:0]  remain;
    logic [NumWidth-1:0]  outRemain;
    ccuWordT              inWordU;
    sramWordT             hold [2];
    logic                 wrPtr;
    logic                 rdPtr;
    logic [1:0]           holdCnt;
    logic                 inGo;
    logic                 popGo;

    // ========================================================================
    // Datapath
    // ========================================================================
    assign inWordU     = strm.inWord;
    assign strm.inRdy  = (state == StFetch) || (state == StLoad);
    assign inGo        = strm.inVld && strm.inRdy;
    assign strm.dirOut = (state == StStore);

    assign glb.wrEn   = inGo && (state == StLoad);
    assign glb.wrAddr = addr;
    assign glb.wrDat  = inWordU.raw;

    // Count the word still in flight so the holding buffer never overflows
    assign glb.rdEn   = (state == StStore) && (remain != '0) &&
                        ((holdCnt + 2'(glb.rdVld)) < 2'd2);
    assign glb.rdAddr = addr;

    assign strm.outVld  = (state == StStore) && (holdCnt != 2'd0);
    assign strm.outWord = hold[rdPtr];
    assign strm.outLast = (outRemain == NumWidth'(1));
    assign popGo        = strm.outVld && strm.outRdy;

    always_ff @(posedge clk) begin
        if (glb.rdVld) begin
            hold[wrPtr] <= glb.rdDat;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr   <= 1'b0;
            rdPtr   <= 1'b0;
            holdCnt <= 2'd0;
        end else begin
            wrPtr   <= wrPtr ^ glb.rdVld;
            rdPtr   <= rdPtr ^ popGo;
            holdCnt <= holdCnt + 2'(glb.rdVld) - 2'(popGo);
        end
    end

    // ========================================================================
    // Instruction FSM
    // ========================================================================
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= StIdle;
            addr      <= '0;
            remain    <= '0;
            outRemain <= '0;
            netFnh    <= 1'b0;
        end else begin
            case (state)
                StIdle: begin
                    if (start) begin
                        netFnh <= 1'b0;
                        state  <= StFetch;
                    end
                end
                StFetch: begin
                    if (inGo) begin
                        addr      <= inWordU.instr.glbAddr;
                        remain    <= inWordU.instr.wordNum;
                        outRemain <= inWordU.instr.wordNum;
                        case (inWordU.instr.opcode)
                            OpLoad: begin
                                if (inWordU.instr.wordNum != '0) begin
                                    state <= StLoad;
                                end
                            end
                            OpStore: begin
                                if (inWordU.instr.wordNum != '0) begin
                                    state <= StStore;
                                end
                            end
                            OpFinish: begin
                                netFnh <= 1'b1;
                                state  <= StIdle;
                            end
                            default: state <= StIdle;
                        endcase
                    end
                end
                StLoad: begin
                    if (inGo) begin
                        addr   <= addr + AddrWidth'(1);
                        remain <= remain - NumWidth'(1);
                        if (remain == NumWidth'(1)) begin
                            state <= StFetch;
                        end
                    end
                end
                default: begin
                    if (glb.rdEn) begin
                        addr   <= addr + AddrWidth'(1);
                        remain <= remain - NumWidth'(1);
                    end
                    // Leave once the final word is handed to the pad side
                    if (popGo) begin
                        outRemain <= outRemain - NumWidth'(1);
                        if (outRemain == NumWidth'(1)) begin
                            state <= StFetch;
                        end
                    end
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        ((state == StFetch) && inGo) |-> (inWordU.instr.opcode != 2'b11))
        else $error("ccuSequencer: illegal opcode fetched");

endmodule

`default_nettype wire

/* src/accTop.sv */
// Pad bus is shared; the host must release padDat, padDatVld and padDatLast while datOe is high
`default_nettype none

module accTop #(
    parameter int DebCycles = 16
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        startPulse,
    inout  wire [accPkg::PortWidth-1:0] padDat,
    inout  wire                         padDatVld,
    inout  wire                         padDatLast,
    inout  wire                         padDatRdy,
    output logic                        datOe,
    output logic                        netFnh
);
    import accPkg::*;

    logic [PortWidth-1:0] padDatOut;
    logic                 padVldOut;
    logic                 padLastOut;
    logic                 padRdyOut;
    logic                 startPls;

    itfStreamIf strmIf ();
    glbPortIf   glbIf ();

    // ========================================================================
    // Pad tristates
    // ========================================================================
    assign padDat     = datOe ? padDatOut : {PortWidth{1'bz}};
    assign padDatVld  = datOe ? padVldOut : 1'bz;
    assign padDatLast = datOe ? padLastOut : 1'bz;
    assign padDatRdy  = datOe ? 1'bz : padRdyOut;

    // ========================================================================
    // Instances
    // ========================================================================
    startDebounce #(
        .DebCycles (DebCycles)
    ) uDeb (
        .clk      (clk),
        .rstN     (rstN),
        .btn      (startPulse),
        .startPls (startPls)
    );

    padItf uPadItf (
        .clk        (clk),
        .rstN       (rstN),
        .padDatIn   (padDat),
        .padVldIn   (padDatVld),
        .padRdyIn   (padDatRdy),
        .padDatOut  (padDatOut),
        .padVldOut  (padVldOut),
        .padLastOut (padLastOut),
        .padRdyOut  (padRdyOut),
        .datOe      (datOe),
        .strm       (strmIf.itf)
    );

    globalBuffer #(
        .Depth (SramWord)
    ) uGlb (
        .clk  (clk),
        .rstN (rstN),
        .port (glbIf.glb)
    );

    ccuSequencer uCcu (
        .clk    (clk),
        .rstN   (rstN),
        .start  (startPls),
        .netFnh (netFnh),
        .strm   (strmIf.ccu),
        .glb    (glbIf.ccu)
    );

endmodule

`default_nettype wire

/* verif/accTopTb.sv */
// Host model drives the shared pad bus 1 ns after each rising edge; run is limited by a watchdog
`default_nettype none

module accTopTb;
    timeunit 1ns;
    timeprecision 100ps;

    import accPkg::*;

    localparam int ClkPeriod    = 8;
    localparam int DebCycles    = 4;
    localparam int Seed         = 28;
    localparam int NumWords     = 8;
    localparam int NumBeats     = 2 * NumWords;
    localparam int BaseAddr     = 10;
    // Synchronizer, debounce count, edge delay and FSM step plus margin
    localparam int StartLatency = DebCycles + 8;
    // Debounce, 22 input beats and 16 stalled output beats need a few hundred cycles
    localparam int BudgetCycles = 2500;

    logic                 clk;
    logic                 rstN;
    logic                 startPulse;
    logic [PortWidth-1:0] hostDat;
    logic                 hostVld;
    logic                 hostRdy;
    logic                 released;
    logic                 storeSent;
    logic                 finishSent;
    logic                 beatOut;
    logic [63:0]          rdyPat;
    int                   rdyIdx;
    int                   rxIdx;
    sramWordT             loadWords [NumWords];
    logic [PortWidth-1:0] expBeat [NumBeats];
    logic [PortWidth-1:0] rxQ [$];

    wire [PortWidth-1:0] padDat;
    wire                 padDatVld;
    wire                 padDatLast;
    wire                 padDatRdy;
    wire                 datOe;
    wire                 netFnh;

    // Host side of the tristate pads
    assign padDat     = datOe ? {PortWidth{1'bz}} : hostDat;
    assign padDatVld  = datOe ? 1'bz : hostVld;
    assign padDatLast = datOe ? 1'bz : 1'b0;
    assign padDatRdy  = datOe ? hostRdy : 1'bz;
    assign beatOut    = datOe && padDatVld && padDatRdy;

    accTop #(
        .DebCycles (DebCycles)
    ) i_accTop (
        .clk        (clk),
        .rstN       (rstN),
        .startPulse (startPulse),
        .padDat     (padDat),
        .padDatVld  (padDatVld),
        .padDatLast (padDatLast),
        .padDatRdy  (padDatRdy),
        .datOe      (datOe),
        .netFnh     (netFnh)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    task automatic reportFail();
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic waitCycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    function automatic sramWordT makeInstr(input opcodeT op, input int num, input int addr);
        instrT ins;
        ins         = '0;
        ins.opcode  = op;
        ins.wordNum = NumWidth'(num);
        ins.glbAddr = AddrWidth'(addr);
        return ins;
    endfunction

    // Holds one beat on the bus until the chip takes it
    task automatic sendBeat(input logic [PortWidth-1:0] beat);
        hostDat = beat;
        hostVld = 1'b1;
        do begin
            @(posedge clk);
        end while (!(datOe === 1'b0 && padDatRdy === 1'b1));
        #1;
        hostVld = 1'b0;
    endtask

    task automatic sendWord(input sramWordT word);
        sendBeat(word[PortWidth-1:0]);
        sendBeat(word[SramWidth-1:PortWidth]);
    endtask

    // Receiver records accepted beats, then sets the next ready level
    always @(posedge clk) begin
        if (beatOut) begin
            rxQ.push_back(padDat);
            rxIdx <= rxIdx + 1;
        end
        #1;
        hostRdy = rdyPat[rdyIdx % 64];
        rdyIdx  = rdyIdx + 1;
    end

    // ========================================================================
    // Checks
    // ========================================================================
    assert property (@(posedge clk) disable iff (!rstN)
        !released |-> (!datOe && !padDatRdy && !netFnh))
        else begin
            $display("[ERROR] afterReset: expected datOe/padDatRdy/netFnh 000, actual %b%b%b",
                     $sampled(datOe), $sampled(padDatRdy), $sampled(netFnh));
            reportFail();
        end

    assert property (@(posedge clk) disable iff (!rstN)
        $rose(released) |-> ##[1:StartLatency] padDatRdy)
        else begin
            $display("Chip never opened the pad input after the start button was released");
            reportFail();
        end

    assert property (@(posedge clk) disable iff (!rstN)
        beatOut |-> (rxIdx < NumBeats))
        else begin
            $display("Chip sent more beats than were loaded");
            reportFail();
        end

    assert property (@(posedge clk) disable iff (!rstN)
        beatOut |-> (padDat == expBeat[rxIdx]))
        else begin
            $display("[ERROR] roundTrip beat %0d: expected %h, actual %h", $sampled(rxIdx),
                     expBeat[$sampled(rxIdx)], $sampled(padDat));
            reportFail();
        end

    assert property (@(posedge clk) disable iff (!rstN)
        beatOut |-> (padDatLast == (rxIdx == NumBeats - 1)))
        else begin
            $display("[ERROR] lastFlag beat %0d: expected %b, actual %b", $sampled(rxIdx),
                     $sampled(rxIdx) == NumBeats - 1, $sampled(padDatLast));
            reportFail();
        end

    assert property (@(posedge clk) disable iff (!rstN)
        (datOe && padDatVld && !padDatRdy) |=>
            (padDatVld && $stable(padDat) && $stable(padDatLast)))
        else begin
            $display("Stalled output beat changed or dropped before the host took it");
            reportFail();
        end

    assert property (@(posedge clk) disable iff (!rstN)
        datOe |-> storeSent)
        else begin
            $display("[ERROR] direction: expected datOe 0 before STORE, actual 1");
            reportFail();
        end

    assert property (@(posedge clk) disable iff (!rstN)
        $fell(datOe) |-> (rxIdx == NumBeats))
        else begin
            $display("[ERROR] direction: expected %0d beats before datOe fell, actual %0d",
                     NumBeats, $sampled(rxIdx));
            reportFail();
        end

    assert property (@(posedge clk) disable iff (!rstN)
        $rose(netFnh) |-> (finishSent && !datOe))
        else begin
            $display("netFnh rose before FINISH was sent or while datOe was high");
            reportFail();
        end

    assert property (@(posedge clk) disable iff (!rstN)
        netFnh |=> (netFnh && !datOe))
        else begin
            $display("netFnh dropped or datOe rose after FINISH");
            reportFail();
        end

    // ========================================================================
    // Stimulus
    // ========================================================================
    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        startPulse = 1'b0;
        hostDat    = '0;
        hostVld    = 1'b0;
        hostRdy    = 1'b0;
        released   = 1'b0;
        storeSent  = 1'b0;
        finishSent = 1'b0;
        rdyIdx     = 0;
        rxIdx      = 0;
        void'($urandom(Seed));
        for (int i = 0; i < NumWords; i++) begin
            for (int j = 0; j < SramWidth / 32; j++) begin
                loadWords[i][j*32 +: 32] = $urandom;
            end
            expBeat[2*i]     = loadWords[i][PortWidth-1:0];
            expBeat[2*i + 1] = loadWords[i][SramWidth-1:PortWidth];
        end
        // Ready is high about two cycles in three
        for (int k = 0; k < 64; k++) begin
            rdyPat[k] = ($urandom % 3) != 0;
        end
        waitCycles(3);
        rstN = 1'b1;
        waitCycles(2);

        // Short glitch is filtered and a held press then release starts the run
        startPulse = 1'b1;
        waitCycles(2);
        startPulse = 1'b0;
        waitCycles(12);
        startPulse = 1'b1;
        waitCycles(10);
        startPulse = 1'b0;
        released   = 1'b1;

        sendWord(makeInstr(OpLoad, NumWords, BaseAddr));
        for (int i = 0; i < NumWords; i++) begin
            sendWord(loadWords[i]);
        end
        sendWord(makeInstr(OpStore, NumWords, BaseAddr));
        storeSent = 1'b1;
        sendWord(makeInstr(OpFinish, 0, 0));
        finishSent = 1'b1;
        wait (netFnh === 1'b1);
        waitCycles(10);

        if (rxQ.size() == NumBeats) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("[ERROR] roundTrip count: expected %0d beats, actual %0d",
                     NumBeats, rxQ.size());
            reportFail();
        end
    end

    initial begin
        #(BudgetCycles * ClkPeriod);
        $display("Watchdog expired before the run finished");
        reportFail();
    end

endmodule

`default_nettype wire

/* vlog.f */
src/accPkg.sv
src/itfStreamIf.sv
src/glbPortIf.sv
src/startDebounce.sv
src/padItf.sv
src/globalBuffer.sv
src/ccuSequencer.sv
src/accTop.sv
verif/accTopTb.sv
